// ==== conv_channel_sum.sv ====
`timescale 1ns/1ns

module conv_channel_sum (
	input  logic                clk,
	input  logic                rst,
	input  logic                ch_valid,
	input  logic                last_in,
	input  conv_data_pkg::acc_t ch_sum [conv_data_pkg::num_ch],
	output conv_data_pkg::acc_t out,
	output logic                valid_out,
	output logic                frame_done
);

	conv_data_pkg::acc_t total;

	always_comb begin
		total = conv_data_pkg::bias;
		for (int k = 0; k < conv_data_pkg::num_ch; k++) begin
			total += ch_sum[k];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_out  <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			valid_out  <= ch_valid;
			frame_done <= ch_valid && last_in; // only ever set on the final output.
		end
	end

	always_ff @(posedge clk) begin
		if (ch_valid) begin
			out <= total;
		end
	end

endmodule

// ==== conv_data_pkg.sv ====
package conv_data_pkg;

	localparam int num_ch = 4;
	localparam int pix_w  = 16;
	localparam int wgt_w  = 8;
	localparam int acc_w  = 32; // wide enough for 4 x 25 products of 16 x 8 bits.

	typedef logic signed [pix_w-1:0] pixel_t;
	typedef logic signed [acc_w-1:0] acc_t;

	// indexed [row][col]; row 0 is the oldest image row, col 0 the leftmost column.
	typedef pixel_t window_t [conv_geom_pkg::kern][conv_geom_pkg::kern];

	// ----------------------------------------------------------------------
	// kernels, indexed [channel][row][col]
	// ----------------------------------------------------------------------

	localparam logic signed [wgt_w-1:0] weights
		[num_ch][conv_geom_pkg::kern][conv_geom_pkg::kern] = '{
		'{
			'{  1, -2,  3,  0,  4},
			'{ -1,  5, -3,  2,  1},
			'{  2,  0,  7, -4, -2},
			'{  3, -1,  1,  6,  0},
			'{ -5,  2, -2,  1,  3}
		},
		'{
			'{  0,  4, -1, -3,  2},
			'{  6, -2,  1,  0, -1},
			'{ -3,  3,  8,  2,  1},
			'{  1,  0, -4,  5, -2},
			'{  2, -6,  0,  1,  4}
		},
		'{
			'{ -2,  1,  0,  3, -1},
			'{  4, -3,  2, -1,  5},
			'{  1,  2, -8,  0,  3},
			'{  0, -1,  3,  2, -4},
			'{  5,  0,  1, -2,  2}
		},
		'{
			'{  3,  0, -2,  1,  1},
			'{ -4,  2,  6, -1,  0},
			'{  1, -5,  2,  4, -3},
			'{  2,  1,  0, -2,  7},
			'{ -1,  3, -1,  0,  2}
		}
	};

	localparam acc_t bias = -37;

endpackage

// ==== conv_frame_fsm.sv ====
`timescale 1ns/1ns

module conv_frame_fsm (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            valid_in,
	input  logic [conv_geom_pkg::col_w-1:0] col,
	input  logic [conv_geom_pkg::row_w-1:0] row,
	output logic                            win_ok,
	output logic                            last_win
);

	// idle is !in_frame, fill is in_frame && !emitting, emit is both set.
	logic in_frame;
	logic emitting;

	logic at_row_end;
	logic fill_done;
	logic win_done;
	logic frame_end;

	assign at_row_end = (col == conv_geom_pkg::img_w - 1);

	// last pixel of the rows that only prime the line buffers.
	assign fill_done = valid_in && at_row_end
		&& (row == conv_geom_pkg::img_h - conv_geom_pkg::out_h - 1);

	// a pixel at or right of this column closes a full window.
	assign win_done = valid_in && emitting
		&& (col >= conv_geom_pkg::img_w - conv_geom_pkg::out_w);

	assign frame_end = win_done && at_row_end && (row == conv_geom_pkg::img_h - 1);

	always_ff @(posedge clk) begin
		if (rst) begin
			in_frame <= 1'b0;
			emitting <= 1'b0;
			win_ok   <= 1'b0;
			last_win <= 1'b0;
		end else begin
			win_ok   <= win_done; // lines up with the window register update.
			last_win <= frame_end;
			if (!in_frame) begin
				if (valid_in && col == '0 && row == '0) begin
					in_frame <= 1'b1;
				end
			end else if (!emitting) begin
				if (fill_done) begin
					emitting <= 1'b1;
				end
			end else if (frame_end) begin
				in_frame <= 1'b0;
				emitting <= 1'b0;
			end
		end
	end

endmodule

// ==== conv_geom_pkg.sv ====
package conv_geom_pkg;

	// ----------------------------------------------------------------------
	// image and kernel geometry
	// ----------------------------------------------------------------------

	localparam int img_w = 8;
	localparam int img_h = 8;
	localparam int kern  = 5; // kernel is kern x kern.

	localparam int out_w = img_w - kern + 1; // window positions along a row.
	localparam int out_h = img_h - kern + 1; // window positions down a column.

	// ----------------------------------------------------------------------
	// position counters
	// ----------------------------------------------------------------------

	localparam int col_w = $clog2(img_w);
	localparam int row_w = $clog2(img_h);

endpackage

// ==== conv_kernel_mac.sv ====
`timescale 1ns/1ns

module conv_kernel_mac #(
	parameter int ch = 0
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   win_ok,
	input  conv_data_pkg::window_t window,
	output logic                   ch_valid,
	output conv_data_pkg::acc_t    ch_sum
);

	conv_data_pkg::acc_t dot;

	// full 25-tap dot product in one cycle, both factors sign extended first.
	always_comb begin
		dot = '0;
		for (int i = 0; i < conv_geom_pkg::kern; i++) begin
			for (int j = 0; j < conv_geom_pkg::kern; j++) begin
				dot += conv_data_pkg::acc_t'(window[i][j])
					* conv_data_pkg::acc_t'(conv_data_pkg::weights[ch][i][j]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ch_valid <= 1'b0;
		end else begin
			ch_valid <= win_ok;
		end
	end

	always_ff @(posedge clk) begin
		if (win_ok) begin
			ch_sum <= dot;
		end
	end

endmodule

// ==== conv_layer.f ====
conv_geom_pkg.sv
conv_data_pkg.sv
pixel_pos_counter.sv
conv_frame_fsm.sv
conv_line_window.sv
conv_kernel_mac.sv
conv_channel_sum.sv
conv_layer_top.sv
tb_conv_layer.sv

// ==== conv_layer_top.sv ====
`timescale 1ns/1ns

module conv_layer_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  valid_in,
	input  conv_data_pkg::pixel_t pix_in [conv_data_pkg::num_ch],
	output conv_data_pkg::acc_t   out,
	output logic                  valid_out,
	output logic                  frame_done
);

	logic [conv_geom_pkg::col_w-1:0] col;
	logic [conv_geom_pkg::row_w-1:0] row;
	logic                            win_ok;
	logic                            last_win;
	logic                            last_in;

	conv_data_pkg::window_t window   [conv_data_pkg::num_ch];
	logic                   ch_valid [conv_data_pkg::num_ch];
	conv_data_pkg::acc_t    ch_sum   [conv_data_pkg::num_ch];

	// ----------------------------------------------------------------------
	// frame control
	// ----------------------------------------------------------------------

	pixel_pos_counter counter_i (
		.clk      (clk),
		.rst      (rst),
		.valid_in (valid_in),
		.col      (col),
		.row      (row)
	);

	conv_frame_fsm fsm_i (
		.clk      (clk),
		.rst      (rst),
		.valid_in (valid_in),
		.col      (col),
		.row      (row),
		.win_ok   (win_ok),
		.last_win (last_win)
	);

	// carries the end of frame past the MAC stage.
	always_ff @(posedge clk) begin
		if (rst) begin
			last_in <= 1'b0;
		end else begin
			last_in <= last_win;
		end
	end

	// ----------------------------------------------------------------------
	// per-channel data paths
	// ----------------------------------------------------------------------

	for (genvar g = 0; g < conv_data_pkg::num_ch; g++) begin : gen_ch
		conv_line_window window_i (
			.clk      (clk),
			.rst      (rst),
			.valid_in (valid_in),
			.pix_in   (pix_in[g]),
			.window   (window[g])
		);

		conv_kernel_mac #(
			.ch (g)
		) mac_i (
			.clk      (clk),
			.rst      (rst),
			.win_ok   (win_ok),
			.window   (window[g]),
			.ch_valid (ch_valid[g]),
			.ch_sum   (ch_sum[g])
		);
	end

	// channels run in lockstep, so channel 0 speaks for all of them.
	conv_channel_sum sum_i (
		.clk        (clk),
		.rst        (rst),
		.ch_valid   (ch_valid[0]),
		.last_in    (last_in),
		.ch_sum     (ch_sum),
		.out        (out),
		.valid_out  (valid_out),
		.frame_done (frame_done)
	);

endmodule

// ==== conv_line_window.sv ====
`timescale 1ns/1ns

module conv_line_window (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    valid_in,
	input  conv_data_pkg::pixel_t   pix_in,
	output conv_data_pkg::window_t  window
);

	// line_buf[i] holds one earlier image row; the highest index is the most recent.
	conv_data_pkg::pixel_t line_buf [conv_geom_pkg::kern-1][conv_geom_pkg::img_w];

	// column that enters the window on the right, oldest row first.
	conv_data_pkg::pixel_t new_col [conv_geom_pkg::kern];

	// ----------------------------------------------------------------------
	// right column of the window
	// ----------------------------------------------------------------------

	always_comb begin
		for (int i = 0; i < conv_geom_pkg::kern - 1; i++) begin
			new_col[i] = line_buf[i][conv_geom_pkg::img_w-1]; // same column, kern-1-i rows up.
		end
		new_col[conv_geom_pkg::kern-1] = pix_in;
	end

	// ----------------------------------------------------------------------
	// line buffers
	// ----------------------------------------------------------------------

	// each row buffer is fed by the row below it, the last one by pix_in.
	always_ff @(posedge clk) begin
		if (valid_in) begin
			for (int i = 0; i < conv_geom_pkg::kern - 1; i++) begin
				for (int j = conv_geom_pkg::img_w - 1; j > 0; j--) begin
					line_buf[i][j] <= line_buf[i][j-1];
				end
				line_buf[i][0] <= new_col[i+1];
			end
		end
	end

	// ----------------------------------------------------------------------
	// sliding window
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			window <= '{default: '0};
		end else if (valid_in) begin
			for (int i = 0; i < conv_geom_pkg::kern; i++) begin
				for (int j = 0; j < conv_geom_pkg::kern - 1; j++) begin
					window[i][j] <= window[i][j+1]; // shift one column left.
				end
				window[i][conv_geom_pkg::kern-1] <= new_col[i];
			end
		end
	end

endmodule

// ==== pixel_pos_counter.sv ====
`timescale 1ns/1ns

module pixel_pos_counter (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            valid_in,
	output logic [conv_geom_pkg::col_w-1:0] col,
	output logic [conv_geom_pkg::row_w-1:0] row
);

	logic col_last;
	logic row_last;

	assign col_last = (col == conv_geom_pkg::img_w - 1);
	assign row_last = (row == conv_geom_pkg::img_h - 1);

	// col and row name the pixel accepted on the next valid edge.
	always_ff @(posedge clk) begin
		if (rst) begin
			col <= '0;
			row <= '0;
		end else if (valid_in) begin
			if (col_last) begin
				col <= '0;
				if (row_last) begin
					row <= '0; // next frame starts here.
				end else begin
					row <= row + 1'b1;
				end
			end else begin
				col <= col + 1'b1;
			end
		end
	end

endmodule

// ==== tb_conv_layer.sv ====
`timescale 1ns/1ns

module tb_conv_layer;

	localparam int rst_cycles  = 8;
	localparam int num_frames  = 4;
	localparam int max_gap     = 2;
	localparam int outs_frame  = conv_geom_pkg::out_w * conv_geom_pkg::out_h;
	localparam int pipe_delay  = 3; // acceptance edge to the edge that sees valid_out.
	// four frames of 64 pixels with up to two idle cycles each need at most about 800.
	localparam int cycle_limit = 1000;

	typedef struct packed {
		int                  due;
		conv_data_pkg::acc_t value;
		logic                last;
		int                  frame;
		int                  r;
		int                  c;
	} exp_t;

	logic                  clk;
	logic                  rst;
	logic                  valid_in;
	conv_data_pkg::pixel_t pix_in [conv_data_pkg::num_ch];
	conv_data_pkg::acc_t   out;
	logic                  valid_out;
	logic                  frame_done;

	conv_data_pkg::pixel_t frame_mem
		[conv_data_pkg::num_ch][conv_geom_pkg::img_h][conv_geom_pkg::img_w];
	exp_t exp_q [$];
	int   cycle      = 0;
	int   m_col      = 0;
	int   m_row      = 0;
	int   m_frame    = 0;
	int   ones_value;

	conv_layer_top dut_i (
		.clk        (clk),
		.rst        (rst),
		.valid_in   (valid_in),
		.pix_in     (pix_in),
		.out        (out),
		.valid_out  (valid_out),
		.frame_done (frame_done)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------

	function automatic int window_sum(input int r0, input int c0);
		int acc;
		acc = conv_data_pkg::bias;
		for (int ch = 0; ch < conv_data_pkg::num_ch; ch++) begin
			for (int i = 0; i < conv_geom_pkg::kern; i++) begin
				for (int j = 0; j < conv_geom_pkg::kern; j++) begin
					acc += int'(frame_mem[ch][r0+i][c0+j])
						* int'(conv_data_pkg::weights[ch][i][j]);
				end
			end
		end
		return acc;
	endfunction

	// an all-ones window reduces every product to its weight.
	function automatic int weight_total();
		int acc;
		acc = conv_data_pkg::bias;
		for (int ch = 0; ch < conv_data_pkg::num_ch; ch++) begin
			for (int i = 0; i < conv_geom_pkg::kern; i++) begin
				for (int j = 0; j < conv_geom_pkg::kern; j++) begin
					acc += int'(conv_data_pkg::weights[ch][i][j]);
				end
			end
		end
		return acc;
	endfunction

	function automatic string test_name(input int frame);
		return (frame == 0) ? "all_ones_frame" : $sformatf("random_frame_%0d", frame);
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	// ----------------------------------------------------------------------
	// monitor and checks
	// ----------------------------------------------------------------------

	task automatic accept_pixel();
		exp_t e;
		for (int ch = 0; ch < conv_data_pkg::num_ch; ch++) begin
			frame_mem[ch][m_row][m_col] = pix_in[ch];
		end
		if (m_row >= conv_geom_pkg::kern - 1 && m_col >= conv_geom_pkg::kern - 1) begin
			e.due   = cycle + pipe_delay;
			e.r     = m_row - (conv_geom_pkg::kern - 1);
			e.c     = m_col - (conv_geom_pkg::kern - 1);
			e.value = window_sum(e.r, e.c);
			e.last  = (m_row == conv_geom_pkg::img_h - 1) && (m_col == conv_geom_pkg::img_w - 1);
			e.frame = m_frame;
			exp_q.push_back(e);
		end
		if (m_col == conv_geom_pkg::img_w - 1) begin
			m_col = 0;
			if (m_row == conv_geom_pkg::img_h - 1) begin
				m_row = 0;
				m_frame++;
			end else begin
				m_row++;
			end
		end else begin
			m_col++;
		end
	endtask

	task automatic check_output(input exp_t e);
		string name;
		name = test_name(e.frame);
		assert (valid_out === 1'b1) else report_failure($sformatf(
			"mismatch %s: valid_out at window (%0d,%0d) expected 1 actual %b",
			name, e.r, e.c, valid_out));
		if (e.frame == 0) begin
			assert (out === conv_data_pkg::acc_t'(ones_value)) else report_failure($sformatf(
				"mismatch %s: weight sum at window (%0d,%0d) expected %0d actual %0d",
				name, e.r, e.c, ones_value, out));
		end else begin
			assert (out === e.value) else report_failure($sformatf(
				"mismatch %s: out at window (%0d,%0d) expected %0d actual %0d",
				name, e.r, e.c, e.value, out));
		end
		assert (frame_done === e.last) else report_failure($sformatf(
			"mismatch %s: frame_done at window (%0d,%0d) expected %b actual %b",
			name, e.r, e.c, e.last, frame_done));
	endtask

	always @(posedge clk) begin
		exp_t e;
		cycle = cycle + 1;
		if (cycle >= cycle_limit) begin
			report_failure("timeout: the run did not finish within the cycle limit");
		end
		if (!rst) begin
			if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
				e = exp_q.pop_front();
				check_output(e);
			end else begin
				assert (valid_out === 1'b0)
					else report_failure("valid_out pulsed on a cycle where no output was due");
			end
			if (valid_in === 1'b1) accept_pixel();
		end
	end

	frame_done_with_output: assert property (@(posedge clk) disable iff (rst)
		frame_done |-> valid_out)
		else report_failure("frame_done pulsed without a valid_out");

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------

	task automatic send_frame(input bit ones);
		int gap;
		for (int p = 0; p < conv_geom_pkg::img_w * conv_geom_pkg::img_h; p++) begin
			gap = $urandom_range(0, max_gap);
			repeat (gap) begin
				@(posedge clk);
				valid_in <= 1'b0;
			end
			@(posedge clk);
			valid_in <= 1'b1;
			for (int ch = 0; ch < conv_data_pkg::num_ch; ch++) begin
				pix_in[ch] <= ones ? conv_data_pkg::pixel_t'(1)
					: conv_data_pkg::pixel_t'($urandom);
			end
		end
	endtask

	initial begin
		void'($urandom(32'h0f893843));
		ones_value = weight_total();
		rst      = 1'b1;
		valid_in = 1'b0;
		for (int ch = 0; ch < conv_data_pkg::num_ch; ch++) begin
			pix_in[ch] = '0;
		end
		repeat (rst_cycles) @(posedge clk);
		rst <= 1'b0;

		send_frame(1'b1);
		for (int f = 1; f < num_frames; f++) begin
			send_frame(1'b0); // frames follow each other with no pause.
		end
		@(posedge clk);
		valid_in <= 1'b0;

		while (exp_q.size() != 0) @(posedge clk);
		repeat (4) @(posedge clk); // room for a stray pulse to show up.

		$display("TEST PASSED");
		$finish;
	end

endmodule
